/* logic/user_io_pkg.sv */
// shared byte types, spi receive and key event structs, command and key codes, fifo size
`default_nettype none

package user_io_pkg;

	// one byte on the spi or ps/2 side
	typedef logic [7:0] byte_t;

	// position in the frame, 0 is the command byte, saturates at the top
	typedef logic [9:0] byte_idx_t;

	// received byte handed from the spi slave to the decoders
	typedef struct packed {
		logic      strb;
		byte_idx_t idx;
		byte_t     data;
	} spi_rx_t;

	// data byte of the buttons/switches command, top bit not used
	typedef struct packed {
		logic       spare;
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} but_sw_t;

	// decoded keyboard event
	typedef struct packed {
		logic  pressed;
		logic  extended;
		byte_t code;
	} key_event_t;

	// commands from the io controller
	localparam byte_t CMD_BUT_SW   = 8'h01;
	localparam byte_t CMD_KBD      = 8'h05;
	localparam byte_t CMD_CONF_STR = 8'h14;
	localparam byte_t CMD_STATUS   = 8'h1e;
	localparam byte_t CMD_JOY0     = 8'h60;
	localparam byte_t CMD_JOY1     = 8'h61;
	localparam byte_t CMD_FEATURES = 8'h80;

	// ps/2 set 2 prefixes
	localparam byte_t KEY_EXT   = 8'he0;
	localparam byte_t KEY_BREAK = 8'hf0;

	// 8 bit core type, sent during the command byte
	localparam byte_t CORE_TYPE = 8'ha4;

	// keyboard fifo address width
	localparam int PS2_FIFO_BITS = 4;

endpackage

`default_nettype wire

/* logic/spi_slave.sv */
// spi slave: line synchronizers, edge detect, bit and byte counters, byte assembly, miso shifter
`default_nettype none

module spi_slave (
	input  wire                        clk_sys,
	input  wire                        SPI_SS_IO,
	input  wire                        spi_clk_i,
	input  wire                        spi_mosi_i,
	input  wire user_io_pkg::byte_t    tx_byte_i,
	output logic                       spi_miso_o,
	output user_io_pkg::spi_rx_t       rx_o
);

	// two flops per line, spi clock is only sampled
	logic [1:0]             sck_sync = 2'b00;
	logic [1:0]             mosi_sync = 2'b00;
	logic                   sck_d = 1'b0;
	logic                   sck_rise;
	logic                   sck_fall;
	logic [2:0]             bit_cnt;
	user_io_pkg::byte_idx_t byte_cnt;
	logic [6:0]             sbuf;
	user_io_pkg::byte_t     shreg;
	// first reply byte loaded after ss falls
	logic                   primed;

	always_ff @(posedge clk_sys) begin
		sck_sync  <= {sck_sync[0], spi_clk_i};
		mosi_sync <= {mosi_sync[0], spi_mosi_i};
		sck_d     <= sck_sync[1];
	end

	assign sck_rise = sck_sync[1] & ~sck_d;
	assign sck_fall = ~sck_sync[1] & sck_d;

	// mosi sampled on rising edges, msb first
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= 3'd0;
			byte_cnt <= '0;
			sbuf     <= 7'd0;
			rx_o     <= '0;
		end else begin
			rx_o.strb <= 1'b0;
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				sbuf    <= {sbuf[5:0], mosi_sync[1]};
				// eighth bit completes the byte
				if (bit_cnt == 3'd7) begin
					rx_o.strb <= 1'b1;
					rx_o.idx  <= byte_cnt;
					rx_o.data <= {sbuf, mosi_sync[1]};
					if (byte_cnt != '1)
						byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// reply byte goes out on falling edges
	// the falling edge after a byte end loads the next reply,
	// by then the responder has updated tx_byte_i
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			primed     <= 1'b0;
			shreg      <= '0;
			spi_miso_o <= 1'b0;
		end else if (!primed || (sck_fall && bit_cnt == 3'd0)) begin
			primed     <= 1'b1;
			shreg      <= {tx_byte_i[6:0], 1'b0};
			spi_miso_o <= tx_byte_i[7];
		end else if (sck_fall) begin
			shreg      <= {shreg[6:0], 1'b0};
			spi_miso_o <= shreg[7];
		end
	end

	// a byte takes eight sampled edges, so strobes never touch
	assert property (@(posedge clk_sys) disable iff (SPI_SS_IO) rx_o.strb |=> !rx_o.strb);

endmodule

`default_nettype wire

/* logic/spi_responder.sv */
// spi reply selection: core type, config string and feature word per command and byte position
`default_nettype none

module spi_responder #(
	parameter int                  STRLEN   = 1,
	parameter logic [8*STRLEN-1:0] CONF_STR = 8'h00,
	parameter logic [31:0]         FEATURES = 32'h0
) (
	input  wire                         clk_sys,
	input  wire                         SPI_SS_IO,
	input  wire user_io_pkg::spi_rx_t   rx_i,
	output user_io_pkg::byte_t          tx_byte_o
);

	user_io_pkg::byte_t cmd_q;
	user_io_pkg::byte_t cmd_sel;
	user_io_pkg::byte_t reply;

	// during byte 0 the command is still on the bus
	assign cmd_sel = (rx_i.idx == '0) ? rx_i.data : cmd_q;

	// reply for the byte after the one just received
	always_comb begin : pick
		int pos;
		pos   = int'(rx_i.idx) + 1;
		reply = '0;
		case (cmd_sel)
			user_io_pkg::CMD_CONF_STR: begin
				// leftmost character first
				if (pos <= STRLEN)
					reply = CONF_STR[(STRLEN - pos) * 8 +: 8];
			end
			user_io_pkg::CMD_FEATURES: begin
				// echo of the command, then feature word msb first
				if (pos == 1)
					reply = user_io_pkg::CMD_FEATURES;
				else if (pos <= 5)
					reply = FEATURES[(5 - pos) * 8 +: 8];
			end
			default: reply = '0;
		endcase
	end

	// core type waits for the next frame
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd_q     <= '0;
			tx_byte_o <= user_io_pkg::CORE_TYPE;
		end else if (rx_i.strb) begin
			if (rx_i.idx == '0)
				cmd_q <= rx_i.data;
			tx_byte_o <= reply;
		end
	end

endmodule

`default_nettype wire

/* logic/cmd_decoder.sv */
// command decoder: buttons, joysticks, status word, key events and keyboard fifo feed
`default_nettype none

module cmd_decoder (
	input  wire                         clk_sys,
	input  wire                         SPI_SS_IO,
	input  wire user_io_pkg::spi_rx_t   rx_i,
	output user_io_pkg::but_sw_t        but_sw_o,
	output logic [31:0]                 joystick_0_o,
	output logic [31:0]                 joystick_1_o,
	output logic [63:0]                 status_o,
	output user_io_pkg::key_event_t     key_o,
	output logic                        key_strobe_o,
	output logic                        kbd_wr_o,
	output user_io_pkg::byte_t          kbd_byte_o
);

	user_io_pkg::byte_t      cmd_q;
	logic                    key_ext_q;
	logic                    key_pressed_q;
	logic                    data_byte;
	logic                    is_prefix;
	// byte lane of a data byte, byte 1 is lane 0
	logic [2:0]              lane;
	// results survive ss, start from zero
	user_io_pkg::but_sw_t    but_sw_q = '0;
	logic [31:0]             joy0_q = '0;
	logic [31:0]             joy1_q = '0;
	logic [63:0]             status_q = '0;
	user_io_pkg::key_event_t key_q = '0;

	assign data_byte = rx_i.strb && (rx_i.idx != '0);
	assign lane      = rx_i.idx[2:0] - 3'd1;
	assign is_prefix = (rx_i.data == user_io_pkg::KEY_EXT) ||
		(rx_i.data == user_io_pkg::KEY_BREAK);

	// command latch, key flags and strobes
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd_q         <= '0;
			key_ext_q     <= 1'b0;
			key_pressed_q <= 1'b1;
			key_strobe_o  <= 1'b0;
			kbd_wr_o      <= 1'b0;
		end else begin
			key_strobe_o <= 1'b0;
			kbd_wr_o     <= 1'b0;
			if (rx_i.strb && rx_i.idx == '0) begin
				cmd_q         <= rx_i.data;
				key_ext_q     <= 1'b0;
				key_pressed_q <= 1'b1;
			end else if (data_byte && cmd_q == user_io_pkg::CMD_KBD) begin
				// every scan code also goes to the ps/2 line
				kbd_wr_o <= 1'b1;
				if (rx_i.data == user_io_pkg::KEY_EXT) begin
					key_ext_q <= 1'b1;
				end else if (rx_i.data == user_io_pkg::KEY_BREAK) begin
					key_pressed_q <= 1'b0;
				end else begin
					// event emitted, flags fresh for the next key
					key_strobe_o  <= 1'b1;
					key_ext_q     <= 1'b0;
					key_pressed_q <= 1'b1;
				end
			end
		end
	end

	// result registers
	always_ff @(posedge clk_sys) begin
		if (data_byte) begin
			case (cmd_q)
				user_io_pkg::CMD_BUT_SW: but_sw_q <= user_io_pkg::but_sw_t'(rx_i.data);
				user_io_pkg::CMD_JOY0: begin
					if (rx_i.idx <= 10'd4)
						joy0_q[{lane[1:0], 3'b000} +: 8] <= rx_i.data;
				end
				user_io_pkg::CMD_JOY1: begin
					if (rx_i.idx <= 10'd4)
						joy1_q[{lane[1:0], 3'b000} +: 8] <= rx_i.data;
				end
				// low byte first
				user_io_pkg::CMD_STATUS: begin
					if (rx_i.idx <= 10'd8)
						status_q[{lane, 3'b000} +: 8] <= rx_i.data;
				end
				user_io_pkg::CMD_KBD: begin
					kbd_byte_o <= rx_i.data;
					if (!is_prefix)
						key_q <= {key_pressed_q, key_ext_q, rx_i.data};
				end
				default: ;
			endcase
		end
	end

	assign but_sw_o     = but_sw_q;
	assign joystick_0_o = joy0_q;
	assign joystick_1_o = joy1_q;
	assign status_o     = status_q;
	assign key_o        = key_q;

	// key strobe only while a keyboard command is open
	assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		key_strobe_o |-> cmd_q == user_io_pkg::CMD_KBD);

endmodule

`default_nettype wire

/* logic/ps2_byte_fifo.sv */
// keyboard scan code fifo, circular buffer that drops writes when full
`default_nettype none

module ps2_byte_fifo (
	input  wire                      clk_sys,
	input  wire                      wr_i,
	input  wire user_io_pkg::byte_t  wr_byte_i,
	input  wire                      rd_i,
	output user_io_pkg::byte_t       rd_byte_o,
	output logic                     empty_o
);

	localparam int AW = user_io_pkg::PS2_FIFO_BITS;

	user_io_pkg::byte_t mem [2**AW];
	// extra top bit tells full from empty
	logic [AW:0]        wptr = '0;
	logic [AW:0]        rptr = '0;
	logic               full;

	assign empty_o   = (wptr == rptr);
	assign full      = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
	// head of queue always visible
	assign rd_byte_o = mem[rptr[AW-1:0]];

	always_ff @(posedge clk_sys) begin
		// full fifo, byte is lost
		if (wr_i && !full) begin
			mem[wptr[AW-1:0]] <= wr_byte_i;
			wptr              <= wptr + 1'b1;
		end
		if (rd_i && !empty_o)
			rptr <= rptr + 1'b1;
	end

	// the transmitter only pops a present byte
	assert property (@(posedge clk_sys) rd_i |-> !empty_o);

endmodule

`default_nettype wire

/* logic/ps2_serializer.sv */
// ps/2 keyboard transmitter: clock divider, 11 bit frame shifter, gated clock output
`default_nettype none

module ps2_serializer #(
	parameter int PS2_DIV = 100
) (
	input  wire                      clk_sys,
	input  wire                      empty_i,
	input  wire user_io_pkg::byte_t  byte_i,
	output logic                     rd_o,
	output logic                     ps2_kbd_clk_o,
	output logic                     ps2_kbd_data_o
);

	localparam int CW = $clog2(PS2_DIV + 1) + 1;

	logic [CW-1:0]      div_cnt = '0;
	logic               ps2_clk = 1'b0;
	// cycle where the internal clock goes high
	logic               rise;
	// 0 idle, 1 to 11 bits of the frame
	logic [3:0]         state = 4'd0;
	user_io_pkg::byte_t tx_byte = '0;
	logic               parity = 1'b1;
	logic               data_q = 1'b1;

	// free running, half period PS2_DIV+1 cycles
	always_ff @(posedge clk_sys) begin
		if (div_cnt == CW'(PS2_DIV)) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign rise = (div_cnt == CW'(PS2_DIV)) && !ps2_clk;
	// pop while idle with data waiting
	assign rd_o = rise && (state == 4'd0) && !empty_i;

	// data moves on rising edges, host samples on falling ones
	always_ff @(posedge clk_sys) begin
		if (rise) begin
			if (state == 4'd0) begin
				data_q <= 1'b1;
				if (!empty_i) begin
					tx_byte <= byte_i;
					parity  <= 1'b1;
					state   <= 4'd1;
					// start bit
					data_q  <= 1'b0;
				end
			end else begin
				if (state <= 4'd8) begin
					// lsb first, parity tracks the ones
					data_q  <= tx_byte[0];
					tx_byte <= {1'b0, tx_byte[7:1]};
					parity  <= parity ^ tx_byte[0];
				end else if (state == 4'd9) begin
					data_q <= parity;
				end else begin
					// stop bit
					data_q <= 1'b1;
				end
				state <= (state == 4'd11) ? 4'd0 : state + 4'd1;
			end
		end
	end

	// clock only toggles inside a frame
	assign ps2_kbd_clk_o  = ps2_clk | (state == 4'd0);
	assign ps2_kbd_data_o = data_q;

	assert property (@(posedge clk_sys) state <= 4'd11);

endmodule

`default_nettype wire

/* logic/user_io.sv */
// top level: spi slave, reply selection, command decoder, keyboard fifo and ps/2 transmitter
`default_nettype none

module user_io #(
	parameter int                  STRLEN   = 1,
	parameter logic [8*STRLEN-1:0] CONF_STR = "A",
	parameter logic [31:0]         FEATURES = 32'h0,
	parameter int                  PS2_DIV  = 100
) (
	input  wire                      clk_sys,
	input  wire                      SPI_SS_IO,
	input  wire                      spi_clk_i,
	input  wire                      spi_mosi_i,
	output logic                     spi_miso_o,
	output logic [1:0]               buttons_o,
	output logic [1:0]               switches_o,
	output logic                     scandoubler_disable_o,
	output logic                     ypbpr_o,
	output logic                     no_csync_o,
	output logic [31:0]              joystick_0_o,
	output logic [31:0]              joystick_1_o,
	output logic [63:0]              status_o,
	output user_io_pkg::key_event_t  key_o,
	output logic                     key_strobe_o,
	output logic                     ps2_kbd_clk_o,
	output logic                     ps2_kbd_data_o
);

	user_io_pkg::spi_rx_t rx;
	user_io_pkg::byte_t   tx_byte;
	user_io_pkg::but_sw_t but_sw;
	// decoder to fifo
	logic                 kbd_wr;
	user_io_pkg::byte_t   kbd_byte;
	// fifo to transmitter
	logic                 fifo_rd;
	logic                 fifo_empty;
	user_io_pkg::byte_t   fifo_byte;

	spi_slave spi_slave_i (
		.clk_sys    (clk_sys),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_clk_i  (spi_clk_i),
		.spi_mosi_i (spi_mosi_i),
		.tx_byte_i  (tx_byte),
		.spi_miso_o (spi_miso_o),
		.rx_o       (rx)
	);

	spi_responder #(
		.STRLEN   (STRLEN),
		.CONF_STR (CONF_STR),
		.FEATURES (FEATURES)
	) spi_responder_i (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.rx_i      (rx),
		.tx_byte_o (tx_byte)
	);

	cmd_decoder cmd_decoder_i (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.rx_i         (rx),
		.but_sw_o     (but_sw),
		.joystick_0_o (joystick_0_o),
		.joystick_1_o (joystick_1_o),
		.status_o     (status_o),
		.key_o        (key_o),
		.key_strobe_o (key_strobe_o),
		.kbd_wr_o     (kbd_wr),
		.kbd_byte_o   (kbd_byte)
	);

	ps2_byte_fifo ps2_byte_fifo_i (
		.clk_sys   (clk_sys),
		.wr_i      (kbd_wr),
		.wr_byte_i (kbd_byte),
		.rd_i      (fifo_rd),
		.rd_byte_o (fifo_byte),
		.empty_o   (fifo_empty)
	);

	ps2_serializer #(
		.PS2_DIV (PS2_DIV)
	) ps2_serializer_i (
		.clk_sys        (clk_sys),
		.empty_i        (fifo_empty),
		.byte_i         (fifo_byte),
		.rd_o           (fifo_rd),
		.ps2_kbd_clk_o  (ps2_kbd_clk_o),
		.ps2_kbd_data_o (ps2_kbd_data_o)
	);

	// buttons/switches byte split into single outputs
	assign buttons_o             = but_sw.buttons;
	assign switches_o            = but_sw.switches;
	assign scandoubler_disable_o = but_sw.scandoubler_disable;
	assign ypbpr_o               = but_sw.ypbpr;
	assign no_csync_o            = but_sw.no_csync;

endmodule

`default_nettype wire

/* sim/tb_user_io.sv */
// user_io testbench with spi master, ps/2 and key event monitors, directed tests and timeout
`default_nettype none

module tb_user_io;
	timeunit 1ns;
	timeprecision 1ps;

	// spi half period in clk_sys cycles
	localparam int SPI_HALF = 4;
	// about 50 spi bytes of 64 cycles, ss gaps and ps/2 drain stay under 5000 cycles
	localparam int TIMEOUT_CYCLES = 20000;

	typedef struct packed {
		logic       start_ok;
		logic       parity_ok;
		logic       stop_ok;
		logic [7:0] data;
	} ps2_rx_t;

	logic        clk_sys;
	logic        SPI_SS_IO;
	logic        spi_clk;
	logic        spi_mosi;
	logic        spi_miso;
	logic [1:0]  buttons;
	logic [1:0]  switches;
	logic        scandoubler_disable;
	logic        ypbpr;
	logic        no_csync;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [63:0] status;
	logic [9:0]  key;
	logic        key_strobe_o;
	logic        ps2_kbd_clk_o;
	logic        ps2_kbd_data_o;

	logic [7:0]  tx_q [$];
	logic [7:0]  rx_q [$];
	logic [9:0]  key_q [$];
	ps2_rx_t     ps2_q [$];
	logic [31:0] rng = 32'h97054a2f;
	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	logic        ps2_clk_prev = 1'b1;
	logic [10:0] ps2_bits = '0;
	int          ps2_nbits = 0;

	user_io #(
		.STRLEN   (4),
		.CONF_STR ("AB;C"),
		.FEATURES (32'h12345678),
		.PS2_DIV  (3)
	) dut_i (
		.clk_sys               (clk_sys),
		.SPI_SS_IO             (SPI_SS_IO),
		.spi_clk_i             (spi_clk),
		.spi_mosi_i            (spi_mosi),
		.spi_miso_o            (spi_miso),
		.buttons_o             (buttons),
		.switches_o            (switches),
		.scandoubler_disable_o (scandoubler_disable),
		.ypbpr_o               (ypbpr),
		.no_csync_o            (no_csync),
		.joystick_0_o          (joystick_0),
		.joystick_1_o          (joystick_1),
		.status_o              (status),
		.key_o                 (key),
		.key_strobe_o          (key_strobe_o),
		.ps2_kbd_clk_o         (ps2_kbd_clk_o),
		.ps2_kbd_data_o        (ps2_kbd_data_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// run limit
	initial begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// one key event per strobe
	always @(negedge clk_sys) begin
		if (key_strobe_o === 1'b1)
			key_q.push_back(key);
	end

	// ps/2 host side takes a bit at each falling clock seen in clk_sys
	always @(negedge clk_sys) begin : ps2_monitor
		ps2_rx_t fr;
		if (ps2_clk_prev && !ps2_kbd_clk_o) begin
			// bits enter from the top so the start bit ends in bit 0
			ps2_bits = {ps2_kbd_data_o, ps2_bits[10:1]};
			ps2_nbits++;
			if (ps2_nbits == 11) begin
				fr.start_ok  = !ps2_bits[0];
				fr.data      = ps2_bits[8:1];
				// odd parity over data and parity bit
				fr.parity_ok = (ps2_bits[9] == ~^ps2_bits[8:1]);
				fr.stop_ok   = ps2_bits[10];
				ps2_q.push_back(fr);
				ps2_nbits = 0;
			end
		end
		ps2_clk_prev = ps2_kbd_clk_o;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		$display("%s: %0d errors", name, errors - err_start);
	endtask

	// command byte and then n data bytes of val with the low byte first
	task automatic build_frame(input logic [7:0] cmd, input logic [63:0] val, input int n);
		int i;
		tx_q.delete();
		tx_q.push_back(cmd);
		for (i = 0; i < n; i++)
			tx_q.push_back(val[i*8 +: 8]);
	endtask

	// sends tx_q in mode 0 msb first and fills rx_q with the miso bytes
	task automatic spi_frame();
		logic [7:0] rx_byte;
		int         i;
		int         b;
		rx_q.delete();
		SPI_SS_IO = 1'b0;
		wait_cycles(SPI_HALF);
		for (i = 0; i < tx_q.size(); i++) begin
			for (b = 7; b >= 0; b--) begin
				spi_clk  = 1'b0;
				spi_mosi = tx_q[i][b];
				wait_cycles(SPI_HALF);
				// miso settled since the falling edge
				rx_byte[b] = spi_miso;
				spi_clk    = 1'b1;
				wait_cycles(SPI_HALF);
			end
			rx_q.push_back(rx_byte);
		end
		spi_clk  = 1'b0;
		spi_mosi = 1'b0;
		wait_cycles(SPI_HALF);
		SPI_SS_IO = 1'b1;
		wait_cycles(8);
		check_value("miso byte 0", rx_q[0], 8'ha4);
	endtask

	task automatic after_reset();
		int err0;
		err0 = errors;
		check_value("key_strobe_o", key_strobe_o, 1'b0);
		check_value("spi_miso_o", spi_miso, 1'b0);
		check_value("key events", key_q.size(), 0);
		report_test("reset", err0);
	endtask

	task automatic buttons_and_joysticks();
		int          err0;
		logic [31:0] joy;
		err0 = errors;
		// 0111_0101
		build_frame(8'h01, 64'h75, 1);
		spi_frame();
		check_value("buttons_o", buttons, 2'b01);
		check_value("switches_o", switches, 2'b01);
		check_value("scandoubler_disable_o", scandoubler_disable, 1'b1);
		check_value("ypbpr_o", ypbpr, 1'b1);
		check_value("no_csync_o", no_csync, 1'b1);
		rng = xorshift32(rng);
		joy = rng;
		build_frame(8'h60, joy, 4);
		spi_frame();
		check_value("joystick_0_o", joystick_0, joy);
		rng = xorshift32(rng);
		joy = rng;
		build_frame(8'h61, joy, 4);
		spi_frame();
		check_value("joystick_1_o", joystick_1, joy);
		report_test("buttons and joysticks", err0);
	endtask

	task automatic status_word();
		int          err0;
		int          k;
		logic [63:0] val;
		err0 = errors;
		for (k = 0; k < 2; k++) begin
			rng = xorshift32(rng);
			val[31:0] = rng;
			rng = xorshift32(rng);
			val[63:32] = rng;
			build_frame(8'h1e, val, 8);
			spi_frame();
			check_value("status_o", status, val);
		end
		report_test("status word", err0);
	endtask

	task automatic key_events();
		int err0;
		err0 = errors;
		key_q.delete();
		ps2_q.delete();
		// data bytes 1c, e0 75, f0 1c
		build_frame(8'h05, 64'h1c_f0_75_e0_1c, 5);
		spi_frame();
		check_value("key event count", key_q.size(), 3);
		if (key_q.size() == 3) begin
			// {pressed, extended, code}
			check_value("key_o event 0", key_q[0], {1'b1, 1'b0, 8'h1c});
			check_value("key_o event 1", key_q[1], {1'b1, 1'b1, 8'h75});
			check_value("key_o event 2", key_q[2], {1'b0, 1'b0, 8'h1c});
		end
		report_test("key events", err0);
	endtask

	task automatic ps2_stream();
		int         err0;
		int         i;
		logic [7:0] exp [5];
		err0 = errors;
		exp[0] = 8'h1c;
		exp[1] = 8'he0;
		exp[2] = 8'h75;
		exp[3] = 8'hf0;
		exp[4] = 8'h1c;
		while (ps2_q.size() < 5)
			@(negedge clk_sys);
		// let the last frame return to idle
		wait_cycles(16);
		check_value("ps2 byte count", ps2_q.size(), 5);
		for (i = 0; i < 5; i++) begin
			check_value("ps2 data", ps2_q[i].data, exp[i]);
			check_value("ps2 start bit ok", ps2_q[i].start_ok, 1'b1);
			check_value("ps2 parity ok", ps2_q[i].parity_ok, 1'b1);
			check_value("ps2 stop bit ok", ps2_q[i].stop_ok, 1'b1);
		end
		check_value("ps2_kbd_clk_o", ps2_kbd_clk_o, 1'b1);
		check_value("ps2_kbd_data_o", ps2_kbd_data_o, 1'b1);
		report_test("ps2 stream", err0);
	endtask

	task automatic config_readback();
		int err0;
		err0 = errors;
		build_frame(8'h14, 64'h0, 5);
		spi_frame();
		check_value("conf byte 1", rx_q[1], "A");
		check_value("conf byte 2", rx_q[2], "B");
		check_value("conf byte 3", rx_q[3], ";");
		check_value("conf byte 4", rx_q[4], "C");
		check_value("conf byte 5", rx_q[5], 8'h00);
		build_frame(8'h80, 64'h0, 5);
		spi_frame();
		check_value("features byte 1", rx_q[1], 8'h80);
		check_value("features byte 2", rx_q[2], 8'h12);
		check_value("features byte 3", rx_q[3], 8'h34);
		check_value("features byte 4", rx_q[4], 8'h56);
		check_value("features byte 5", rx_q[5], 8'h78);
		report_test("config readback", err0);
	endtask

	initial begin : main
		SPI_SS_IO = 1'b1;
		spi_clk   = 1'b0;
		spi_mosi  = 1'b0;
		wait_cycles(8);
		after_reset();
		buttons_and_joysticks();
		status_word();
		key_events();
		ps2_stream();
		config_readback();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
logic/user_io_pkg.sv
logic/spi_slave.sv
logic/spi_responder.sv
logic/cmd_decoder.sv
logic/ps2_byte_fifo.sv
logic/ps2_serializer.sv
logic/user_io.sv
sim/tb_user_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the user_io testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_user_io -o tb_user_io &&
./obj_dir/tb_user_io | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
